// ==== rv_pkg.sv ====
/*
 * encodings shared by the RV32I multicycle core, a subset of the base ISA only
 * ALU codes and select codes are local to this core and not from any spec
 */
`default_nettype none

package rv_pkg;

    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_lui    = 7'b0110111,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_branch = 7'b1100011,
        opc_jal    = 7'b1101111,
        opc_system = 7'b1110011
    } opcode_t;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor,
        alu_slt, alu_sll, alu_srl, alu_pass_b
    } alu_fn_t;

    typedef enum logic [1:0] {
        sel_a_rs1, sel_a_pc, sel_a_last_pc, sel_a_zero
    } sel_a_t;

    typedef enum logic [1:0] {
        sel_b_rs2, sel_b_imm, sel_b_four
    } sel_b_t;

    typedef enum logic [1:0] {
        wb_alu_out, wb_mem_data, wb_pc, wb_imm
    } wb_sel_t;

    // opcode, rd and funct3 slots sit at the same bits in every view
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_t    opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_t     opcode;
    } i_type_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        opcode_t    opcode;
    } s_type_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        opcode_t    opcode;
    } b_type_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        opcode_t     opcode;
    } u_type_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        opcode_t    opcode;
    } j_type_t;

    typedef union packed {
        r_type_t r;
        i_type_t i;
        s_type_t s;
        b_type_t b;
        u_type_t u;
        j_type_t j;
    } rv_inst_u;

endpackage

`default_nettype wire

// ==== alu.sv ====
/*
 * purely combinational, shifts use operand_b[4:0] only
 * slt is signed, there is no unsigned compare
 */
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  wire rv_pkg::alu_fn_t alu_function,
    input  wire logic [31:0]     operand_a,
    input  wire logic [31:0]     operand_b,
    output logic [31:0]          result,
    output logic                 result_equal_zero
);

    always_comb begin
        case (alu_function)
            rv_pkg::alu_add:    result = operand_a + operand_b;
            rv_pkg::alu_sub:    result = operand_a - operand_b;
            rv_pkg::alu_and:    result = operand_a & operand_b;
            rv_pkg::alu_or:     result = operand_a | operand_b;
            rv_pkg::alu_xor:    result = operand_a ^ operand_b;
            rv_pkg::alu_slt:    result = {31'd0, $signed(operand_a) < $signed(operand_b)};
            rv_pkg::alu_sll:    result = operand_a << operand_b[4:0];
            rv_pkg::alu_srl:    result = operand_a >> operand_b[4:0];
            rv_pkg::alu_pass_b: result = operand_b;
            default:            result = 32'd0;
        endcase
    end

    // branches compare with sub, so equal means zero
    assign result_equal_zero = (result == 32'd0);

endmodule

`default_nettype wire

// ==== regfile.sv ====
/*
 * no reset, contents are undefined until written
 * x0 is never stored and always reads as zero
 */
`timescale 1ns/1ps
`default_nettype none

module regfile (
    input  wire logic        clock,
    input  wire logic        write_enable,
    input  wire logic [4:0]  rd_address,
    input  wire logic [4:0]  rs1_address,
    input  wire logic [4:0]  rs2_address,
    input  wire logic [31:0] rd_data,
    output logic [31:0]      rs1_data,
    output logic [31:0]      rs2_data
);

    logic [31:0] registers [0:31];

    always_ff @(posedge clock) begin
        if (write_enable && rd_address != 5'd0) begin
            registers[rd_address] <= rd_data;
        end
    end

    assign rs1_data = (rs1_address == 5'd0) ? 32'd0 : registers[rs1_address];
    assign rs2_data = (rs2_address == 5'd0) ? 32'd0 : registers[rs2_address];

    x0_rs1_zero: assert property (@(posedge clock)
        rs1_address == 5'd0 |-> rs1_data == 32'd0);
    x0_rs2_zero: assert property (@(posedge clock)
        rs2_address == 5'd0 |-> rs2_data == 32'd0);

endmodule

`default_nettype wire

// ==== immediate_generator.sv ====
/*
 * immediate for I, S, B, U and J formats, zero for R format and system
 */
`timescale 1ns/1ps
`default_nettype none

module immediate_generator (
    input  wire rv_pkg::rv_inst_u inst,
    output logic [31:0]           immediate
);

    always_comb begin
        case (inst.r.opcode)
            rv_pkg::opc_op_imm, rv_pkg::opc_load: begin
                immediate = {{20{inst.i.imm_11_0[11]}}, inst.i.imm_11_0};
            end
            rv_pkg::opc_store: begin
                immediate = {{20{inst.s.imm_11_5[6]}}, inst.s.imm_11_5, inst.s.imm_4_0};
            end
            // branch and jump offsets are in halfwords
            rv_pkg::opc_branch: begin
                immediate = {{19{inst.b.imm_12}}, inst.b.imm_12, inst.b.imm_11,
                             inst.b.imm_10_5, inst.b.imm_4_1, 1'b0};
            end
            rv_pkg::opc_jal: begin
                immediate = {{11{inst.j.imm_20}}, inst.j.imm_20, inst.j.imm_19_12,
                             inst.j.imm_11, inst.j.imm_10_1, 1'b0};
            end
            rv_pkg::opc_lui: begin
                immediate = {inst.u.imm_31_12, 12'd0};
            end
            default: begin
                immediate = 32'd0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== multicycle_datapath.sv ====
/*
 * one memory port shared by fetch and data, selected by inst_or_data
 * only pc and last pc are reset, every other register holds data only
 */
`timescale 1ns/1ps
`default_nettype none

module multicycle_datapath #(
    parameter logic [31:0] RESET_PC = 32'd0
) (
    input  wire logic             clock,
    input  wire logic             rst_n,
    input  wire logic [31:0]      mem_read_data,
    output logic [31:0]           mem_address,
    output logic [31:0]           mem_write_data,
    output rv_pkg::opcode_t       opcode,
    output logic [2:0]            funct3,
    output logic                  funct7_bit5,
    output logic                  alu_zero,
    input  wire rv_pkg::alu_fn_t  alu_function,
    input  wire rv_pkg::sel_a_t   alu_operand_a_select,
    input  wire rv_pkg::sel_b_t   alu_operand_b_select,
    input  wire logic             next_pc_select,
    input  wire logic             pc_write_enable,
    input  wire logic             last_pc_write_enable,
    input  wire logic             inst_write_enable,
    input  wire logic             data_write_enable,
    input  wire logic             regfile_write_enable,
    input  wire rv_pkg::wb_sel_t  reg_writeback_select,
    input  wire logic             inst_or_data
);

    rv_pkg::rv_inst_u inst;
    logic [31:0] pc;
    logic [31:0] last_pc;
    logic [31:0] next_pc;
    logic [31:0] data;
    logic [31:0] alu_out;
    logic [31:0] rs1_out;
    logic [31:0] rs2_out;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    logic [31:0] rd_data;
    logic [31:0] immediate;
    logic [31:0] alu_operand_a;
    logic [31:0] alu_operand_b;
    logic [31:0] alu_result;

    assign opcode      = inst.r.opcode;
    assign funct3      = inst.r.funct3;
    assign funct7_bit5 = inst.r.funct7[5];

    regfile regfile_inst (
        .clock        (clock),
        .write_enable (regfile_write_enable),
        .rd_address   (inst.r.rd),
        .rs1_address  (inst.r.rs1),
        .rs2_address  (inst.r.rs2),
        .rd_data      (rd_data),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data)
    );

    immediate_generator immediate_generator_inst (
        .inst      (inst),
        .immediate (immediate)
    );

    alu alu_inst (
        .alu_function      (alu_function),
        .operand_a         (alu_operand_a),
        .operand_b         (alu_operand_b),
        .result            (alu_result),
        .result_equal_zero (alu_zero)
    );

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            pc      <= RESET_PC;
            last_pc <= RESET_PC;
        end else begin
            if (pc_write_enable) begin
                pc <= next_pc;
            end
            if (last_pc_write_enable) begin
                last_pc <= pc;
            end
        end
    end

    // alu out and the operand registers load every cycle
    always_ff @(posedge clock) begin
        if (inst_write_enable) begin
            inst <= mem_read_data;
        end
        if (data_write_enable) begin
            data <= mem_read_data;
        end
        alu_out <= alu_result;
        rs1_out <= rs1_data;
        rs2_out <= rs2_data;
    end

    always_comb begin
        case (alu_operand_a_select)
            rv_pkg::sel_a_rs1:     alu_operand_a = rs1_out;
            rv_pkg::sel_a_pc:      alu_operand_a = pc;
            rv_pkg::sel_a_last_pc: alu_operand_a = last_pc;
            default:               alu_operand_a = 32'd0;
        endcase
        case (alu_operand_b_select)
            rv_pkg::sel_b_rs2:  alu_operand_b = rs2_out;
            rv_pkg::sel_b_imm:  alu_operand_b = immediate;
            rv_pkg::sel_b_four: alu_operand_b = 32'd4;
            default:            alu_operand_b = 32'd0;
        endcase
        case (reg_writeback_select)
            rv_pkg::wb_alu_out:  rd_data = alu_out;
            rv_pkg::wb_mem_data: rd_data = data;
            rv_pkg::wb_pc:       rd_data = pc;
            default:             rd_data = immediate;
        endcase
    end

    assign next_pc        = next_pc_select ? alu_out : {alu_result[31:1], 1'b0};
    assign mem_address    = inst_or_data ? alu_out : pc;
    assign mem_write_data = rs2_out;

    // only word accesses are supported
    data_word_aligned: assert property (@(posedge clock) disable iff (!rst_n)
        inst_or_data |-> mem_address[1:0] == 2'b00);

endmodule

`default_nettype wire

// ==== multicycle_control.sv ====
/*
 * fetch, decode, execute, memory, writeback; ecall parks the FSM in halt
 * unsupported opcodes pass through execute with no effect
 */
`timescale 1ns/1ps
`default_nettype none

module multicycle_control (
    input  wire logic            clock,
    input  wire logic            rst_n,
    input  wire rv_pkg::opcode_t opcode,
    input  wire logic [2:0]      funct3,
    input  wire logic            funct7_bit5,
    input  wire logic            alu_zero,
    output rv_pkg::alu_fn_t      alu_function,
    output rv_pkg::sel_a_t       alu_operand_a_select,
    output rv_pkg::sel_b_t       alu_operand_b_select,
    output logic                 next_pc_select,
    output logic                 pc_write_enable,
    output logic                 last_pc_write_enable,
    output logic                 inst_write_enable,
    output logic                 data_write_enable,
    output logic                 regfile_write_enable,
    output rv_pkg::wb_sel_t      reg_writeback_select,
    output logic                 inst_or_data,
    output logic                 mem_write_enable,
    output logic                 halted
);

    typedef enum logic [2:0] {
        st_fetch, st_decode, st_execute, st_memory, st_writeback, st_halt
    } state_t;

    state_t state;
    state_t next_state;
    logic   branch_taken;

    function automatic rv_pkg::alu_fn_t decode_alu(input logic [2:0] f3, input logic use_sub);
        case (f3)
            3'b000:  decode_alu = use_sub ? rv_pkg::alu_sub : rv_pkg::alu_add;
            3'b001:  decode_alu = rv_pkg::alu_sll;
            3'b010:  decode_alu = rv_pkg::alu_slt;
            3'b100:  decode_alu = rv_pkg::alu_xor;
            3'b101:  decode_alu = rv_pkg::alu_srl;
            3'b110:  decode_alu = rv_pkg::alu_or;
            3'b111:  decode_alu = rv_pkg::alu_and;
            default: decode_alu = rv_pkg::alu_add;
        endcase
    endfunction

    // funct3 bit 0 set means bne
    assign branch_taken = funct3[0] ? !alu_zero : alu_zero;
    assign halted       = (state == st_halt);

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_fetch;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        alu_function         = rv_pkg::alu_pass_b;
        alu_operand_a_select = rv_pkg::sel_a_zero;
        alu_operand_b_select = rv_pkg::sel_b_rs2;
        next_pc_select       = 1'b0;
        pc_write_enable      = 1'b0;
        last_pc_write_enable = 1'b0;
        inst_write_enable    = 1'b0;
        data_write_enable    = 1'b0;
        regfile_write_enable = 1'b0;
        reg_writeback_select = rv_pkg::wb_alu_out;
        inst_or_data         = 1'b0;
        mem_write_enable     = 1'b0;
        next_state           = state;
        case (state)
            st_fetch: begin
                inst_write_enable    = 1'b1;
                last_pc_write_enable = 1'b1;
                pc_write_enable      = 1'b1;
                alu_function         = rv_pkg::alu_add;
                alu_operand_a_select = rv_pkg::sel_a_pc;
                alu_operand_b_select = rv_pkg::sel_b_four;
                next_state           = st_decode;
            end
            st_decode: begin
                // branch and jump target lands in alu out
                alu_function         = rv_pkg::alu_add;
                alu_operand_a_select = rv_pkg::sel_a_last_pc;
                alu_operand_b_select = rv_pkg::sel_b_imm;
                next_state = (opcode == rv_pkg::opc_system) ? st_halt : st_execute;
            end
            st_execute: begin
                alu_operand_a_select = rv_pkg::sel_a_rs1;
                next_state           = st_fetch;
                case (opcode)
                    rv_pkg::opc_op: begin
                        alu_function = decode_alu(funct3, funct7_bit5);
                        next_state   = st_writeback;
                    end
                    rv_pkg::opc_op_imm: begin
                        alu_function         = decode_alu(funct3, 1'b0);
                        alu_operand_b_select = rv_pkg::sel_b_imm;
                        next_state           = st_writeback;
                    end
                    rv_pkg::opc_load, rv_pkg::opc_store: begin
                        alu_function         = rv_pkg::alu_add;
                        alu_operand_b_select = rv_pkg::sel_b_imm;
                        next_state           = st_memory;
                    end
                    rv_pkg::opc_branch: begin
                        alu_function    = rv_pkg::alu_sub;
                        next_pc_select  = 1'b1;
                        pc_write_enable = branch_taken;
                    end
                    rv_pkg::opc_jal: begin
                        regfile_write_enable = 1'b1;
                        reg_writeback_select = rv_pkg::wb_pc;
                        next_pc_select       = 1'b1;
                        pc_write_enable      = 1'b1;
                    end
                    rv_pkg::opc_lui: begin
                        regfile_write_enable = 1'b1;
                        reg_writeback_select = rv_pkg::wb_imm;
                    end
                    default: begin
                        alu_operand_a_select = rv_pkg::sel_a_zero;
                    end
                endcase
            end
            st_memory: begin
                inst_or_data = 1'b1;
                if (opcode == rv_pkg::opc_store) begin
                    mem_write_enable = 1'b1;
                    next_state       = st_fetch;
                end else begin
                    data_write_enable = 1'b1;
                    next_state        = st_writeback;
                end
            end
            st_writeback: begin
                regfile_write_enable = 1'b1;
                if (opcode == rv_pkg::opc_load) begin
                    reg_writeback_select = rv_pkg::wb_mem_data;
                end
                next_state = st_fetch;
            end
            st_halt: begin
                next_state = st_halt;
            end
            default: begin
                next_state = st_fetch;
            end
        endcase
    end

    // store strobe only in memory and for the instruction seen in execute
    store_in_memory: assert property (@(posedge clock) disable iff (!rst_n)
        mem_write_enable |-> state == st_memory && $stable(opcode));

endmodule

`default_nettype wire

// ==== multicycle_core.sv ====
/*
 * memory reads must answer in the same cycle, writes happen on the clock edge
 * no bus handshake and no stall input
 */
`timescale 1ns/1ps
`default_nettype none

module multicycle_core #(
    parameter logic [31:0] RESET_PC = 32'd0
) (
    input  wire logic        clock,
    input  wire logic        rst_n,
    input  wire logic [31:0] mem_read_data,
    output logic [31:0]      mem_address,
    output logic [31:0]      mem_write_data,
    output logic             mem_write_enable,
    output logic             halted
);

    rv_pkg::opcode_t opcode;
    logic [2:0]      funct3;
    logic            funct7_bit5;
    logic            alu_zero;
    rv_pkg::alu_fn_t alu_function;
    rv_pkg::sel_a_t  alu_operand_a_select;
    rv_pkg::sel_b_t  alu_operand_b_select;
    rv_pkg::wb_sel_t reg_writeback_select;
    logic            next_pc_select;
    logic            pc_write_enable;
    logic            last_pc_write_enable;
    logic            inst_write_enable;
    logic            data_write_enable;
    logic            regfile_write_enable;
    logic            inst_or_data;

    multicycle_datapath #(
        .RESET_PC (RESET_PC)
    ) multicycle_datapath_inst (
        .clock                (clock),
        .rst_n                (rst_n),
        .mem_read_data        (mem_read_data),
        .mem_address          (mem_address),
        .mem_write_data       (mem_write_data),
        .opcode               (opcode),
        .funct3               (funct3),
        .funct7_bit5          (funct7_bit5),
        .alu_zero             (alu_zero),
        .alu_function         (alu_function),
        .alu_operand_a_select (alu_operand_a_select),
        .alu_operand_b_select (alu_operand_b_select),
        .next_pc_select       (next_pc_select),
        .pc_write_enable      (pc_write_enable),
        .last_pc_write_enable (last_pc_write_enable),
        .inst_write_enable    (inst_write_enable),
        .data_write_enable    (data_write_enable),
        .regfile_write_enable (regfile_write_enable),
        .reg_writeback_select (reg_writeback_select),
        .inst_or_data         (inst_or_data)
    );

    multicycle_control multicycle_control_inst (
        .clock                (clock),
        .rst_n                (rst_n),
        .opcode               (opcode),
        .funct3               (funct3),
        .funct7_bit5          (funct7_bit5),
        .alu_zero             (alu_zero),
        .alu_function         (alu_function),
        .alu_operand_a_select (alu_operand_a_select),
        .alu_operand_b_select (alu_operand_b_select),
        .next_pc_select       (next_pc_select),
        .pc_write_enable      (pc_write_enable),
        .last_pc_write_enable (last_pc_write_enable),
        .inst_write_enable    (inst_write_enable),
        .data_write_enable    (data_write_enable),
        .regfile_write_enable (regfile_write_enable),
        .reg_writeback_select (reg_writeback_select),
        .inst_or_data         (inst_or_data),
        .mem_write_enable     (mem_write_enable),
        .halted               (halted)
    );

endmodule

`default_nettype wire

// ==== tb_multicycle_core.sv ====
/*
 * runs the program from core_vectors.txt at address 0 and checks every store
 * memory model holds 256 words, addresses alias above 1 KiB
 */
`timescale 1ns/1ps
`default_nettype none

module tb_multicycle_core;

    localparam int CLOCK_PERIOD = 20;
    localparam int MEMORY_WORDS = 256;
    localparam int VECTOR_WORDS = 384;
    localparam int HALT_TIMEOUT = 2000;
    localparam int DRAIN_CYCLES = 20;

    logic        clock;
    logic        rst_n;
    logic [31:0] mem_read_data;
    logic [31:0] mem_address;
    logic [31:0] mem_write_data;
    logic        mem_write_enable;
    logic        halted;

    logic [31:0] memory [0:MEMORY_WORDS-1];
    logic [31:0] vectors [0:VECTOR_WORDS-1];
    logic [31:0] expected_address [$];
    logic [31:0] expected_value [$];
    int          program_words;
    int          expected_stores;
    int          store_count;
    int          check_count;
    int          error_count;

    multicycle_core #(
        .RESET_PC (32'd0)
    ) multicycle_core_inst (
        .clock            (clock),
        .rst_n            (rst_n),
        .mem_read_data    (mem_read_data),
        .mem_address      (mem_address),
        .mem_write_data   (mem_write_data),
        .mem_write_enable (mem_write_enable),
        .halted           (halted)
    );

    initial begin
        clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    // reads answer in the same cycle, writes land on the rising edge
    assign mem_read_data = memory[mem_address[9:2]];

    always @(posedge clock) begin
        if (mem_write_enable) begin
            memory[mem_address[9:2]] <= mem_write_data;
        end
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Fail %s: got %h, expected %h", name, actual, expected);
        end
    endtask

    task automatic record_store(input logic [31:0] address, input logic [31:0] value);
        int errors_before;
        errors_before = error_count;
        store_count++;
        if (expected_address.size() == 0) begin
            error_count++;
            $display("store %0d to %h came after the last expected store", store_count, address);
        end else begin
            check_value("mem_address", address, expected_address.pop_front());
            check_value("mem_write_data", value, expected_value.pop_front());
            if (error_count == errors_before) begin
                $display("store %0d to %h value %h: ok", store_count, address, value);
            end else begin
                $display("store %0d to %h: mismatch", store_count, address);
            end
        end
    endtask

    // mid-cycle sampling, all core outputs are settled here
    always @(negedge clock) begin
        if (rst_n && mem_write_enable) begin
            record_store(mem_address, mem_write_data);
        end
    end

    initial begin
        int cycles;
        rst_n         = 1'b0;
        program_words = 0;
        store_count   = 0;
        check_count   = 0;
        error_count   = 0;
        for (int i = 0; i < VECTOR_WORDS; i++) begin
            vectors[i] = 32'd0;
        end
        $readmemh("core_vectors.txt", vectors);

        // fill pattern carries the whole word address
        for (int i = 0; i < MEMORY_WORDS; i++) begin
            memory[i] <= 32'ha5a50000 | i;
        end
        // records are kind, address, value; kind 1 program word, kind 2 store
        for (int i = 0; i + 2 < VECTOR_WORDS; i += 3) begin
            if (vectors[i] == 32'd1) begin
                memory[vectors[i+1][9:2]] <= vectors[i+2];
                program_words++;
            end else if (vectors[i] == 32'd2) begin
                expected_address.push_back(vectors[i+1]);
                expected_value.push_back(vectors[i+2]);
            end else if (vectors[i] != 32'd0) begin
                error_count++;
                $display("vector record at word %0d has an unknown kind %h", i, vectors[i]);
            end
        end
        expected_stores = expected_address.size();
        if (program_words == 0) begin
            error_count++;
            $display("no program words were read from core_vectors.txt");
        end
        $display("loaded %0d program words and %0d expected stores",
                 program_words, expected_stores);

        repeat (4) @(posedge clock);
        check_value("halted", {31'd0, halted}, 32'd0);
        check_value("mem_write_enable", {31'd0, mem_write_enable}, 32'd0);
        check_value("mem_address", mem_address, 32'd0);
        $display("reset state: %0d errors so far", error_count);
        rst_n <= 1'b1;

        cycles = 0;
        while (!halted && cycles < HALT_TIMEOUT) begin
            @(negedge clock);
            cycles++;
        end
        if (!halted) begin
            error_count++;
            $display("timeout: the core did not halt within %0d cycles", HALT_TIMEOUT);
        end else begin
            $display("halt after %0d cycles: ok", cycles);
        end

        // any store after ecall shows up in the count
        repeat (DRAIN_CYCLES) @(negedge clock);
        check_value("store_count", store_count, expected_stores);
        $display("store count %0d of %0d expected", store_count, expected_stores);

        $display("checks %0d, errors %0d, stores %0d", check_count, error_count, store_count);
        if (error_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== core_vectors.txt ====
// columns: kind address value, all hex
// kind 1 is a program word, kind 2 an expected store in program order
1 00000000 00c00093 // addi x1, x0, 12
1 00000004 ffb00113 // addi x2, x0, -5
1 00000008 002081b3 // add  x3, x1, x2
1 0000000c 20302023 // sw   x3, 0x200(x0)
2 00000200 00000007
1 00000010 40208233 // sub  x4, x1, x2
1 00000014 20402223 // sw   x4, 0x204(x0)
2 00000204 00000011
1 00000018 0020f2b3 // and  x5, x1, x2
1 0000001c 20502423 // sw   x5, 0x208(x0)
2 00000208 00000008
1 00000020 0020e333 // or   x6, x1, x2
1 00000024 20602623 // sw   x6, 0x20c(x0)
2 0000020c ffffffff
1 00000028 0020c3b3 // xor  x7, x1, x2
1 0000002c 20702823 // sw   x7, 0x210(x0)
2 00000210 fffffff7
1 00000030 00112433 // slt  x8, x2, x1
1 00000034 20802a23 // sw   x8, 0x214(x0)
2 00000214 00000001
1 00000038 001094b3 // sll  x9, x1, x1
1 0000003c 20902c23 // sw   x9, 0x218(x0)
2 00000218 0000c000
1 00000040 001155b3 // srl  x11, x2, x1
1 00000044 20b02e23 // sw   x11, 0x21c(x0)
2 0000021c 000fffff
1 00000048 0f017613 // andi x12, x2, 0x0f0
1 0000004c 22c02023 // sw   x12, 0x220(x0)
2 00000220 000000f0
1 00000050 70566693 // ori  x13, x12, 0x705
1 00000054 22d02223 // sw   x13, 0x224(x0)
2 00000224 000007f5
1 00000058 fff6c713 // xori x14, x13, -1
1 0000005c 22e02423 // sw   x14, 0x228(x0)
2 00000228 fffff80a
1 00000060 00572793 // slti x15, x14, 5
1 00000064 22f02623 // sw   x15, 0x22c(x0)
2 0000022c 00000001
1 00000068 20402803 // lw   x16, 0x204(x0)
1 0000006c 23002823 // sw   x16, 0x230(x0)
2 00000230 00000011
1 00000070 06300013 // addi x0, x0, 99
1 00000074 22002a23 // sw   x0, 0x234(x0)
2 00000234 00000000
1 00000078 123458b7 // lui  x17, 0x12345
1 0000007c 23102c23 // sw   x17, 0x238(x0)
2 00000238 12345000
1 00000080 00208463 // beq  x1, x2, +8 not taken
1 00000084 22102e23 // sw   x1, 0x23c(x0)
2 0000023c 0000000c
1 00000088 00209463 // bne  x1, x2, +8 taken
1 0000008c 24202023 // sw   x2, 0x240(x0) skipped
1 00000090 00318463 // beq  x3, x3, +8 taken
1 00000094 24202223 // sw   x2, 0x244(x0) skipped
1 00000098 00109463 // bne  x1, x1, +8 not taken
1 0000009c 24302423 // sw   x3, 0x248(x0)
2 00000248 00000007
1 000000a0 0080096f // jal  x18, +8
1 000000a4 24202623 // sw   x2, 0x24c(x0) skipped
1 000000a8 25202823 // sw   x18, 0x250(x0)
2 00000250 000000a4
1 000000ac 00000073 // ecall
1 000000b0 24102a23 // sw   x1, 0x254(x0) never reached

// ==== list.f ====
rv_pkg.sv
alu.sv
regfile.sv
immediate_generator.sv
multicycle_datapath.sv
multicycle_control.sv
multicycle_core.sv
tb_multicycle_core.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_multicycle_core
FILE_LIST ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= test passed

SOURCES := $(shell grep -v '^+' $(FILE_LIST))

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_TEXT)" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILE_LIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
